//--- vlog.f
+incdir+rtl
+incdir+tests
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_exec_unit.sv
tests/tb_rv_exec_unit.sv

//--- tests/tb_rv_ref.svh
`ifndef TB_RV_REF_SVH
`define TB_RV_REF_SVH

// sign extend from bit w-1
function automatic logic [31:0] sext(input logic [31:0] v, input int w);
	logic signed [31:0] t;
	t = v << (32 - w);
	return t >>> (32 - w);
endfunction

function automatic logic [31:0] imm_i(input logic [31:0] x);
	return sext({20'b0, x[31:20]}, 12);
endfunction

function automatic logic [31:0] imm_s(input logic [31:0] x);
	return sext({20'b0, x[31:25], x[11:7]}, 12);
endfunction

function automatic logic [31:0] imm_b(input logic [31:0] x);
	return sext({19'b0, x[31], x[7], x[30:25], x[11:8], 1'b0}, 13);
endfunction

function automatic logic [31:0] imm_j(input logic [31:0] x);
	return sext({11'b0, x[31], x[19:12], x[20], x[30:21], 1'b0}, 21);
endfunction

// instruction builders
function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// op and op-imm results, alt is bit 30 (sub, sra)
function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
	case (f3)
		3'd0:    return alt ? a - b : a + b;
		3'd1:    return a << b[4:0];
		3'd2:    return {31'b0, $signed(a) < $signed(b)};
		3'd3:    return {31'b0, a < b};
		3'd4:    return a ^ b;
		3'd5:    return alt ? sext(a >> b[4:0], 32 - b[4:0]) : a >> b[4:0];
		3'd6:    return a | b;
		default: return a & b;
	endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
	case (f3)
		3'd0:    return a == b;
		3'd1:    return a != b;
		3'd4:    return $signed(a) < $signed(b);
		3'd5:    return $signed(a) >= $signed(b);
		3'd6:    return a < b;
		default: return a >= b;
	endcase
endfunction

// halves ignore address bit 0
function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] w,
		input logic [31:0] addr);
	case (f3)
		3'd0:    return sext(w >> (8 * addr[1:0]), 8);
		3'd1:    return sext(w >> (16 * addr[1]), 16);
		3'd4:    return (w >> (8 * addr[1:0])) & 32'hff;
		3'd5:    return (w >> (16 * addr[1])) & 32'hffff;
		default: return w;
	endcase
endfunction

function automatic logic [31:0] store_merge(input logic [2:0] f3, input logic [31:0] old,
		input logic [31:0] addr, input logic [31:0] d);
	logic [31:0] m;
	int          s;
	case (f3[1:0])
		2'd0: begin
			s = 8 * addr[1:0];
			m = 32'hff << s;
		end
		2'd1: begin
			s = 16 * addr[1];
			m = 32'hffff << s;
		end
		default: begin
			s = 0;
			m = '1;
		end
	endcase
	return (old & ~m) | ((d << s) & m);
endfunction

`endif

//--- tests/tb_rv_exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module tb_rv_exec_unit import rv_pipe_pkg::*; ();

	localparam int unsigned SEED       = 32'h016ef43d;
	localparam int          RST_CYCLES = 10;
	localparam int          N_INSN     = 221; // 73 alu, 50 mem, 50 branch, 18 jump, 22 bad, 8 hold
	localparam int          LIMIT      = RST_CYCLES + 40 * N_INSN;

	logic      clk;
	logic      rst_n;
	logic      req;
	insn_req_t insn;
	logic      ack;
	retire_t   retire;
	retire_t   exp_ret; // for the request in flight
	word_t     shadow_rf  [`RV_NREGS];
	word_t     shadow_mem [`RV_DMEM_WORDS];
	int        cycles   = 0;
	int        issued   = 0;
	int        ret_errs = 0;
	int        hs_errs  = 0;

	`include "tb_rv_ref.svh"

	rv_exec_unit i_rv_exec_unit (
		.i_clk    (clk),
		.i_rst_n  (rst_n),
		.i_req    (req),
		.i_insn   (insn),
		.o_ack    (ack),
		.o_retire (retire)
	);

	always #5 clk = ~clk; // 10 ns

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == LIMIT) begin
			$display("timeout after %0d cycles, %0d of %0d instructions done, %0d+%0d errors",
				cycles, issued, N_INSN, ret_errs, hs_errs);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// retire record valid for the whole ack phase
	assert property (@(posedge clk) disable iff (!rst_n)
		ack |-> retire.insn_vld == exp_ret.insn_vld && retire.rd_wren == exp_ret.rd_wren
			&& retire.rd == exp_ret.rd && retire.next_pc == exp_ret.next_pc
			&& (!exp_ret.rd_wren || retire.rd_data == exp_ret.rd_data))
	else begin
		ret_errs++;
		$display("[ERROR] o_retire: expected %h, got %h", $sampled(exp_ret), $sampled(retire));
	end

	assert property (@(posedge clk) disable iff (!rst_n) $rose(req) |-> ##2 $rose(ack))
	else begin
		hs_errs++;
		$display("o_ack did not rise two edges after the request was captured");
	end

	assert property (@(posedge clk) disable iff (!rst_n) ack && req |=> ack)
	else begin
		hs_errs++;
		$display("o_ack dropped while the request was still high");
	end

	assert property (@(posedge clk) disable iff (!rst_n) $fell(req) |-> ack ##1 !ack)
	else begin
		hs_errs++;
		$display("o_ack did not fall one edge after the request was lowered");
	end

	function automatic reg_idx_t pick_reg(input int lo, input int hi);
		return reg_idx_t'($urandom_range(hi, lo));
	endfunction

	// golden model, also updates register and memory copies
	task automatic predict(input word_t pc, input word_t w, output retire_t e);
		logic [2:0] f3;
		word_t      a;
		word_t      b;
		word_t      addr;
		dmem_addr_t idx;
		f3 = w[14:12];
		a  = shadow_rf[w[19:15]];
		b  = shadow_rf[w[24:20]];
		e  = '{insn_vld: 1'b1, rd_wren: 1'b1, rd: w[11:7], rd_data: '0, next_pc: pc + 4};
		case (w[6:0])
			7'h37: e.rd_data = {w[31:12], 12'b0};      // lui
			7'h17: e.rd_data = pc + {w[31:12], 12'b0}; // auipc
			7'h6f: begin // jal
				e.rd_data = pc + 4;
				e.next_pc = pc + imm_j(w);
			end
			7'h67: begin // jalr
				e.rd_data  = pc + 4;
				e.next_pc  = (a + imm_i(w)) & ~32'd1;
				e.insn_vld = (f3 == 3'd0);
			end
			7'h63: begin
				e.rd_wren  = 1'b0;
				e.insn_vld = (f3[2:1] != 2'b01);
				if (branch_taken(f3, a, b))
					e.next_pc = pc + imm_b(w);
			end
			7'h03: begin
				addr       = a + imm_i(w);
				e.insn_vld = (f3 != 3'd3) && (f3 < 3'd6);
				e.rd_data  = load_value(f3, shadow_mem[dmem_addr_t'(addr >> 2)], addr);
			end
			7'h23: begin
				addr       = a + imm_s(w);
				idx        = dmem_addr_t'(addr >> 2); // word index, upper bits dropped
				e.rd_wren  = 1'b0;
				e.insn_vld = (f3 < 3'd3);
				if (e.insn_vld)
					shadow_mem[idx] = store_merge(f3, shadow_mem[idx], addr, b);
			end
			7'h13: begin
				e.insn_vld = !(f3 == 3'd1 && w[30]);
				e.rd_data  = alu_result(f3, f3 == 3'd5 && w[30], a, imm_i(w));
			end
			7'h33: begin
				e.insn_vld = !w[30] || f3 == 3'd0 || f3 == 3'd5;
				e.rd_data  = alu_result(f3, w[30], a, b);
			end
			default: e.insn_vld = 1'b0; // system, fence, unknown
		endcase
		if (!e.insn_vld) begin
			e.rd_wren = 1'b0;
			e.next_pc = pc + 4;
		end
		if (e.rd == 5'd0)
			e.rd_wren = 1'b0;
		if (e.rd_wren)
			shadow_rf[e.rd] = e.rd_data;
	endtask

	// one full four-phase transfer at a random pc
	task automatic issue(input word_t w);
		retire_t e;
		word_t   pc;
		int      hold;
		pc = $urandom & 32'hffff_fffc;
		predict(pc, w, e);
		@(posedge clk);
		exp_ret <= e;
		insn    <= '{pc: pc, insn: w};
		req     <= 1'b1;
		do @(posedge clk); while (!ack);
		hold = $urandom_range(5, 0); // slow host
		repeat (hold) @(posedge clk);
		req <= 1'b0;
		do @(posedge clk); while (ack);
		issued++;
	endtask

	task automatic load_reg(input reg_idx_t r, input word_t v);
		word_t hi;
		hi = v + 32'h800; // addi sign-extends its low 12 bits
		issue({hi[31:12], r, 7'h37});
		issue(enc_i(v[11:0], r, 3'd0, r, 7'h13));
	endtask

	task automatic run_alu();
		logic [2:0]  f3;
		logic [11:0] imm;
		for (int r = 1; r <= 8; r++)
			load_reg(reg_idx_t'(r), $urandom);
		for (int n = 0; n < 3; n++) begin
			for (int k = 0; k < 10; k++) begin // 8 and 9 are sub, sra
				f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
				issue({1'b0, k >= 8, 5'b0, pick_reg(0, 8), pick_reg(0, 8), f3,
					pick_reg(0, 8), 7'h33});
			end
			for (int k = 0; k < 9; k++) begin // 8 is srai
				f3  = (k < 8) ? 3'(k) : 3'd5;
				imm = 12'($urandom);
				if (f3 == 3'd1 || f3 == 3'd5)
					imm = {1'b0, k == 8, 5'b0, imm[4:0]};
				issue(enc_i(imm, pick_reg(0, 8), f3, pick_reg(0, 8), 7'h13));
			end
		end
	endtask

	task automatic run_mem();
		logic [11:0] off;
		logic [2:0]  ld_f3;
		load_reg(5'd20, $urandom_range(127, 0)); // base
		for (int n = 0; n < 24; n++) begin
			off   = 12'($urandom_range(127, 0));
			ld_f3 = (n % 5 < 3) ? 3'(n % 5) : 3'(n % 5 + 1); // lb lh lw lbu lhu
			issue(enc_s(off, pick_reg(1, 8), 5'd20, 3'(n % 3)));
			issue(enc_i(off ^ 12'($urandom_range(3, 0)), 5'd20, ld_f3, pick_reg(1, 8), 7'h03));
		end
	endtask

	task automatic run_branch();
		word_t p;
		word_t a [5];
		word_t b [5];
		p = $urandom_range(1000, 1);
		a = '{p, p, p + 5, -p, p};     // equal, less, greater, sign split
		b = '{p, p + 5, p, p, -p};
		for (int n = 0; n < 5; n++) begin
			load_reg(5'd11, a[n]);
			load_reg(5'd12, b[n]);
			for (int k = 0; k < 8; k++) begin
				if (k != 2 && k != 3)
					issue(enc_b(13'($urandom), 5'd12, 5'd11, 3'(k)));
			end
		end
	endtask

	task automatic run_jump();
		for (int n = 0; n < 6; n++) begin
			issue(enc_j(21'($urandom), pick_reg(1, 8)));
			issue(enc_i(12'($urandom), pick_reg(1, 8), 3'd0, pick_reg(1, 8), 7'h67));
			issue({20'($urandom), pick_reg(1, 8), 7'h17}); // auipc
		end
	endtask

	task automatic run_invalid();
		issue({20'h12345, 5'd0, 7'h37});                 // lui x0
		issue(enc_i(12'h7ff, 5'd1, 3'd0, 5'd0, 7'h13));  // addi x0
		issue(enc_i(12'h000, 5'd0, 3'd0, 5'd5, 7'h13));  // x0 readback
		issue(32'h0000_0073);                            // ecall
		issue(32'h0000_000f);                            // fence
		issue({25'($urandom), 7'h7f});
		issue({7'h20, 5'd2, 5'd1, 3'd1, 5'd3, 7'h33});   // sll with bit 30
		issue(enc_i(12'h010, 5'd20, 3'd3, 5'd3, 7'h03));
		issue(enc_i(12'h010, 5'd20, 3'd6, 5'd4, 7'h03));
		issue(enc_s(12'h010, 5'd1, 5'd20, 3'd3));
		issue(enc_b(13'h010, 5'd2, 5'd1, 3'd2));
		issue(enc_i(12'h004, 5'd1, 3'd1, 5'd3, 7'h67));  // jalr funct3 1
		issue(enc_i(12'h401, 5'd1, 3'd1, 5'd3, 7'h13));  // slli with bit 30
		for (int r = 1; r <= 8; r++)
			issue(enc_i(12'h000, reg_idx_t'(r), 3'd0, reg_idx_t'(r), 7'h13));
		issue(enc_i(12'h010, 5'd20, 3'd2, 5'd6, 7'h03)); // word under bad store
	endtask

	// counter bumps, a repeated write would show up
	task automatic run_hold();
		load_reg(5'd9, $urandom);
		for (int n = 0; n < 6; n++)
			issue(enc_i(12'd1, 5'd9, 3'd0, 5'd9, 7'h13));
	endtask

	initial begin
		void'($urandom(SEED));
		clk     = 1'b0;
		rst_n   = 1'b0;
		req     = 1'b0;
		insn    = '0;
		exp_ret = '0;
		foreach (shadow_rf[r])
			shadow_rf[r] = '0;
		foreach (shadow_mem[w])
			shadow_mem[w] = '0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		assert (!ack) else begin
			hs_errs++;
			$display("o_ack was high right after reset");
		end
		run_alu();
		run_mem();
		run_branch();
		run_jump();
		run_invalid();
		run_hold();
		repeat (4) @(posedge clk);
		$display("summary: %0d instructions, %0d retire errors, %0d handshake errors",
			issued, ret_errs, hs_errs);
		if (ret_errs == 0 && hs_errs == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/rv_exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module rv_exec_unit import rv_pipe_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_req,
	input  insn_req_t i_insn,
	output logic      o_ack,
	output retire_t   o_retire
);

	typedef enum logic [1:0] {ST_IDLE, ST_EXEC, ST_ACK} state_e;

	state_e    state;
	insn_req_t insn_q;   // instruction register
	retire_t   retire_q;
	ctrl_t     ctrl;
	exec_t     exec_res;
	word_t     rs1_data;
	word_t     rs2_data;
	word_t     rd_data;
	word_t     next_pc;
	reg_idx_t  rd;
	logic      commit;   // single write cycle per instruction
	logic      br_less;
	logic      br_equal;
	logic      rd_wren;

	// four-phase handshake fsm
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (i_req) state <= ST_EXEC;   // capture edge
				ST_EXEC: state <= ST_ACK;               // write edge
				default: if (!i_req) state <= ST_IDLE;  // wait for req low
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if ((state == ST_IDLE) && i_req) begin
			insn_q <= i_insn;
		end
		if (commit) begin
			retire_q <= '{
				insn_vld: ctrl.insn_vld,
				rd_wren:  rd_wren,
				rd:       rd,
				rd_data:  rd_data,
				next_pc:  next_pc
			};
		end
	end

	assign commit   = (state == ST_EXEC);
	assign rd       = insn_q.insn[11:7];
	assign o_ack    = (state == ST_ACK);
	assign o_retire = retire_q;

	rv_decode i_rv_decode (
		.i_op       (insn_q.insn[6:0]),
		.i_funct3   (insn_q.insn[14:12]),
		.i_funct7_5 (insn_q.insn[30]),
		.i_br_less  (br_less),
		.i_br_equal (br_equal),
		.o_ctrl     (ctrl)
	);

	rv_regfile i_rv_regfile (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_rs1      (insn_q.insn[19:15]),
		.i_rs2      (insn_q.insn[24:20]),
		.i_rd       (rd),
		.i_wr_en    (commit & rd_wren),
		.i_wr_data  (rd_data),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

	rv_execute i_rv_execute (
		.i_insn     (insn_q),
		.i_rs1_data (rs1_data),
		.i_rs2_data (rs2_data),
		.i_ctrl     (ctrl),
		.o_br_less  (br_less),
		.o_br_equal (br_equal),
		.o_exec     (exec_res)
	);

	rv_result i_rv_result (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_commit   (commit),
		.i_ctrl     (ctrl),
		.i_exec     (exec_res),
		.i_rd       (rd),
		.i_funct3   (insn_q.insn[14:12]),
		.o_rd_wren  (rd_wren),
		.o_rd_data  (rd_data),
		.o_next_pc  (next_pc)
	);

endmodule

`default_nettype wire

//--- rtl/rv_result.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_result import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_commit,
	input  ctrl_t      i_ctrl,
	input  exec_t      i_exec,
	input  reg_idx_t   i_rd,
	input  logic [2:0] i_funct3,
	output logic       o_rd_wren,
	output word_t      o_rd_data,
	output word_t      o_next_pc
);

	localparam int AW = $bits(dmem_addr_t);

	word_t       dmem [`RV_DMEM_WORDS];
	dmem_addr_t  addr;
	logic [1:0]  lane;    // byte offset in word
	logic [3:0]  byte_en;
	word_t       st_word;
	word_t       ld_word;
	logic [7:0]  ld_byte;
	logic [15:0] ld_half;
	logic        ld_signed;
	word_t       ld_data;
	logic        is_jalr;

	assign addr = i_exec.alu[AW+1:2]; // upper address bits ignored
	assign lane = i_exec.alu[1:0];

	// store lanes, data replicated across the word
	always_comb begin
		case (i_ctrl.bmask)
			3'b001: begin
				byte_en = 4'b0001 << lane;
				st_word = {4{i_exec.st_data[7:0]}};
			end
			3'b010: begin
				byte_en = lane[1] ? 4'b1100 : 4'b0011; // bit 0 dropped
				st_word = {2{i_exec.st_data[15:0]}};
			end
			default: begin
				byte_en = (i_ctrl.bmask == 3'b100) ? 4'b1111 : 4'b0000;
				st_word = i_exec.st_data;
			end
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int w = 0; w < `RV_DMEM_WORDS; w++) begin
				dmem[w] <= '0;
			end
		end else if (i_commit && i_ctrl.mem_wren) begin
			for (int b = 0; b < 4; b++) begin
				if (byte_en[b]) begin
					dmem[addr][8*b +: 8] <= st_word[8*b +: 8];
				end
			end
		end
	end

	// load extract and extend
	assign ld_word   = dmem[addr];
	assign ld_byte   = ld_word[8*lane +: 8];
	assign ld_half   = lane[1] ? ld_word[31:16] : ld_word[15:0];
	assign ld_signed = ~i_funct3[2]; // lbu/lhu carry funct3[2]

	always_comb begin
		case (i_ctrl.ls_size)
			LS_LB, LS_LBU: ld_data = {{24{ld_signed & ld_byte[7]}}, ld_byte};
			LS_LH, LS_LHU: ld_data = {{16{ld_signed & ld_half[15]}}, ld_half};
			default:       ld_data = ld_word;
		endcase
	end

	always_comb begin
		case (i_ctrl.wb_sel)
			WB_PC4:  o_rd_data = i_exec.pc_plus4; // jal/jalr link
			WB_LOAD: o_rd_data = ld_data;
			default: o_rd_data = i_exec.alu;
		endcase
	end

	assign o_rd_wren = i_ctrl.rd_wren & (i_rd != '0);

	// jalr is the only jump based on rs1
	assign is_jalr = i_ctrl.pc_sel & ~i_ctrl.opa_sel;

	always_comb begin
		if (!i_ctrl.pc_sel)
			o_next_pc = i_exec.pc_plus4;
		else if (is_jalr)
			o_next_pc = {i_exec.alu[31:1], 1'b0};
		else
			o_next_pc = i_exec.alu; // taken branch or jal
	end

endmodule

`default_nettype wire

//--- rtl/rv_execute.sv
`timescale 1ns/100ps
`default_nettype none

module rv_execute import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  insn_req_t i_insn,
	input  word_t     i_rs1_data,
	input  word_t     i_rs2_data,
	input  ctrl_t     i_ctrl,
	output logic      o_br_less,
	output logic      o_br_equal,
	output exec_t     o_exec
);

	word_t      insn;
	word_t      imm;
	word_t      opa;
	word_t      opb;
	word_t      alu;
	logic [4:0] shamt;

	assign insn = i_insn.insn;

	// immediate generator, sign from inst[31]
	always_comb begin
		case (i_ctrl.imm_sel)
			IMM_I:   imm = {{20{insn[31]}}, insn[31:20]};
			IMM_S:   imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
			IMM_B:   imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
			IMM_J:   imm = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
			IMM_U:   imm = {insn[31:12], 12'b0};
			default: imm = '0;
		endcase
	end

	assign opa   = i_ctrl.opa_sel ? i_insn.pc : i_rs1_data;
	assign opb   = i_ctrl.opb_sel ? imm : i_rs2_data;
	assign shamt = opb[4:0]; // only low 5 bits shift

	always_comb begin
		case (i_ctrl.alu_op)
			ALU_ADD:    alu = opa + opb; // also ld/st address, branch target
			ALU_SUB:    alu = opa - opb;
			ALU_SLT:    alu = word_t'($signed(opa) < $signed(opb));
			ALU_SLTU:   alu = word_t'(opa < opb);
			ALU_XOR:    alu = opa ^ opb;
			ALU_OR:     alu = opa | opb;
			ALU_AND:    alu = opa & opb;
			ALU_SLL:    alu = opa << shamt;
			ALU_SRL:    alu = opa >> shamt;
			ALU_SRA:    alu = word_t'($signed(opa) >>> shamt);
			ALU_PASS_B: alu = opb; // lui
			default:    alu = opa + opb;
		endcase
	end

	// branch comparator, always on rs1/rs2
	assign o_br_equal = (i_rs1_data == i_rs2_data);
	assign o_br_less  = i_ctrl.br_signed ? ($signed(i_rs1_data) < $signed(i_rs2_data))
	                                     : (i_rs1_data < i_rs2_data);

	assign o_exec = '{
		alu:      alu,
		st_data:  i_rs2_data,
		pc_plus4: i_insn.pc + 32'd4
	};

endmodule

`default_nettype wire

//--- rtl/rv_regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_regfile import rv_pipe_pkg::*; (
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  reg_idx_t i_rs1,
	input  reg_idx_t i_rs2,
	input  reg_idx_t i_rd,
	input  logic     i_wr_en,
	input  word_t    i_wr_data,
	output word_t    o_rs1_data,
	output word_t    o_rs2_data
);

	// x0 has no storage
	word_t regs [1:`RV_NREGS-1];

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int r = 1; r < `RV_NREGS; r++) begin
				regs[r] <= '0;
			end
		end else if (i_wr_en && (i_rd != '0)) begin // x0 writes dropped
			regs[i_rd] <= i_wr_data;
		end
	end

	// async read ports
	assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

//--- rtl/rv_decode.sv
`timescale 1ns/100ps
`default_nettype none

module rv_decode import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic [6:0] i_op,
	input  logic [2:0] i_funct3,
	input  logic       i_funct7_5,
	input  logic       i_br_less,
	input  logic       i_br_equal,
	output ctrl_t      o_ctrl
);

	logic is_load;
	logic is_alu_imm;
	logic is_auipc;
	logic is_store;
	logic is_alu_reg;
	logic is_lui;
	logic is_branch;
	logic is_jalr;
	logic is_jal;
	logic funct_bad; // opcode known but funct fields are not

	assign is_load    = (i_op == OP_LOAD);   // 3
	assign is_alu_imm = (i_op == OP_IMM);    // 19
	assign is_auipc   = (i_op == OP_AUIPC);  // 23
	assign is_store   = (i_op == OP_STORE);  // 35
	assign is_alu_reg = (i_op == OP_REG);    // 51
	assign is_lui     = (i_op == OP_LUI);    // 55
	assign is_branch  = (i_op == OP_BRANCH); // 99
	assign is_jalr    = (i_op == OP_JALR);   // 103
	assign is_jal     = (i_op == OP_JAL);    // 111

	always_comb begin
		o_ctrl    = '0; // imm i, alu add, wb pc+4
		funct_bad = 1'b0;
		if (is_load) begin
			o_ctrl.rd_wren = 1'b1;
			o_ctrl.opb_sel = 1'b1; // base + offset
			o_ctrl.wb_sel  = WB_LOAD;
			case (i_funct3)
				3'b000:  o_ctrl.ls_size = LS_LB;
				3'b001:  o_ctrl.ls_size = LS_LH;
				3'b010:  o_ctrl.ls_size = LS_LW;
				3'b100:  o_ctrl.ls_size = LS_LBU;
				3'b101:  o_ctrl.ls_size = LS_LHU;
				default: funct_bad = 1'b1;
			endcase
		end else if (is_alu_imm) begin
			o_ctrl.rd_wren = 1'b1;
			o_ctrl.opb_sel = 1'b1;
			o_ctrl.wb_sel  = WB_ALU;
			case (i_funct3)
				3'b000: o_ctrl.alu_op = ALU_ADD;
				3'b001: begin
					o_ctrl.alu_op = ALU_SLL;
					funct_bad     = i_funct7_5; // slli wants bit 30 clear
				end
				3'b010: o_ctrl.alu_op = ALU_SLT;
				3'b011: o_ctrl.alu_op = ALU_SLTU;
				3'b100: o_ctrl.alu_op = ALU_XOR;
				3'b101: o_ctrl.alu_op = i_funct7_5 ? ALU_SRA : ALU_SRL;
				3'b110: o_ctrl.alu_op = ALU_OR;
				default: o_ctrl.alu_op = ALU_AND;
			endcase
		end else if (is_auipc) begin
			o_ctrl.rd_wren = 1'b1;
			o_ctrl.opa_sel = 1'b1; // pc + upper imm
			o_ctrl.opb_sel = 1'b1;
			o_ctrl.imm_sel = IMM_U;
			o_ctrl.wb_sel  = WB_ALU;
		end else if (is_store) begin
			o_ctrl.mem_wren = 1'b1;
			o_ctrl.opb_sel  = 1'b1;
			o_ctrl.imm_sel  = IMM_S;
			case (i_funct3)
				3'b000:  o_ctrl.bmask = 3'b001; // sb
				3'b001:  o_ctrl.bmask = 3'b010; // sh
				3'b010:  o_ctrl.bmask = 3'b100; // sw
				default: funct_bad = 1'b1;
			endcase
		end else if (is_alu_reg) begin
			o_ctrl.rd_wren = 1'b1;
			o_ctrl.wb_sel  = WB_ALU;
			case ({i_funct7_5, i_funct3})
				4'b0_000: o_ctrl.alu_op = ALU_ADD;
				4'b1_000: o_ctrl.alu_op = ALU_SUB;
				4'b0_001: o_ctrl.alu_op = ALU_SLL;
				4'b0_010: o_ctrl.alu_op = ALU_SLT;
				4'b0_011: o_ctrl.alu_op = ALU_SLTU;
				4'b0_100: o_ctrl.alu_op = ALU_XOR;
				4'b0_101: o_ctrl.alu_op = ALU_SRL;
				4'b1_101: o_ctrl.alu_op = ALU_SRA;
				4'b0_110: o_ctrl.alu_op = ALU_OR;
				4'b0_111: o_ctrl.alu_op = ALU_AND;
				default:  funct_bad = 1'b1; // bit 30 set outside sub and sra
			endcase
		end else if (is_lui) begin
			o_ctrl.rd_wren = 1'b1;
			o_ctrl.opb_sel = 1'b1;
			o_ctrl.imm_sel = IMM_U;
			o_ctrl.alu_op  = ALU_PASS_B;
			o_ctrl.wb_sel  = WB_ALU;
		end else if (is_branch) begin
			o_ctrl.opa_sel   = 1'b1; // target = pc + b imm
			o_ctrl.opb_sel   = 1'b1;
			o_ctrl.imm_sel   = IMM_B;
			o_ctrl.br_signed = ~i_funct3[1]; // bltu/bgeu compare unsigned
			case (i_funct3)
				3'b000:          o_ctrl.pc_sel = i_br_equal;
				3'b001:          o_ctrl.pc_sel = ~i_br_equal;
				3'b100, 3'b110:  o_ctrl.pc_sel = i_br_less;
				3'b101, 3'b111:  o_ctrl.pc_sel = ~i_br_less;
				default:         funct_bad = 1'b1;
			endcase
		end else if (is_jalr) begin
			o_ctrl.pc_sel  = 1'b1;
			o_ctrl.rd_wren = 1'b1;
			o_ctrl.opb_sel = 1'b1; // rs1 + i imm
			o_ctrl.wb_sel  = WB_PC4;
			funct_bad      = (i_funct3 != 3'b000);
		end else if (is_jal) begin
			o_ctrl.pc_sel  = 1'b1;
			o_ctrl.rd_wren = 1'b1;
			o_ctrl.opa_sel = 1'b1;
			o_ctrl.opb_sel = 1'b1;
			o_ctrl.imm_sel = IMM_J;
			o_ctrl.wb_sel  = WB_PC4;
		end else begin
			funct_bad = 1'b1; // system, fence, garbage
		end

		// bad encodings retire without side effects
		o_ctrl.insn_vld = ~funct_bad;
		if (funct_bad) begin
			o_ctrl.rd_wren  = 1'b0;
			o_ctrl.mem_wren = 1'b0;
			o_ctrl.pc_sel   = 1'b0; // fall through to pc+4
		end
	end

endmodule

`default_nettype wire

//--- rtl/rv_pipe_pkg.sv
`default_nettype none

`include "rv_core_cfg.svh"

package rv_pipe_pkg;

	import rv_isa_pkg::*;

	typedef logic [`RV_XLEN-1:0]                word_t;
	typedef logic [$clog2(`RV_NREGS)-1:0]       reg_idx_t;
	typedef logic [$clog2(`RV_DMEM_WORDS)-1:0]  dmem_addr_t; // word index, not byte

	// host request
	typedef struct packed {
		word_t pc;
		word_t insn;
	} insn_req_t;

	// decoder output
	typedef struct packed {
		logic     rd_wren;
		logic     opa_sel;   // 1 = pc, 0 = rs1
		logic     opb_sel;   // 1 = imm, 0 = rs2
		logic     pc_sel;    // 1 = take alu result as next pc
		logic     mem_wren;
		logic     br_signed;
		logic     insn_vld;
		imm_sel_e imm_sel;
		alu_op_e  alu_op;
		wb_sel_e  wb_sel;
		ls_size_e ls_size;
		logic [2:0] bmask;   // {sw, sh, sb}
	} ctrl_t;

	typedef struct packed {
		word_t alu;
		word_t st_data;
		word_t pc_plus4;
	} exec_t;

	typedef struct packed {
		logic     insn_vld;
		logic     rd_wren;
		reg_idx_t rd;
		word_t    rd_data;
		word_t    next_pc;
	} retire_t;

endpackage

`default_nettype wire

//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	// rv32i major opcodes, inst[6:0]
	typedef enum logic [6:0] {
		OP_LOAD   = 7'b0000011, // lb lh lw lbu lhu
		OP_IMM    = 7'b0010011, // addi .. srai
		OP_AUIPC  = 7'b0010111,
		OP_STORE  = 7'b0100011, // sb sh sw
		OP_REG    = 7'b0110011, // add .. and
		OP_LUI    = 7'b0110111,
		OP_BRANCH = 7'b1100011, // beq .. bgeu
		OP_JALR   = 7'b1100111,
		OP_JAL    = 7'b1101111
	} opcode_e;

	// alu operation codes
	typedef enum logic [4:0] {
		ALU_ADD    = 5'd0,
		ALU_SUB    = 5'd1,
		ALU_SLT    = 5'd2,
		ALU_SLTU   = 5'd3,
		ALU_XOR    = 5'd4,
		ALU_OR     = 5'd5,
		ALU_AND    = 5'd6,
		ALU_SLL    = 5'd7,
		ALU_SRL    = 5'd8,
		ALU_SRA    = 5'd9,
		ALU_PASS_B = 5'd10 // lui, operand b straight through
	} alu_op_e;

	// immediate layout
	typedef enum logic [2:0] {IMM_I = 3'd0, IMM_S = 3'd1, IMM_B = 3'd2, IMM_J = 3'd3, IMM_U = 3'd4} imm_sel_e;

	// register writeback source
	typedef enum logic [1:0] {WB_PC4 = 2'd0, WB_ALU = 2'd1, WB_LOAD = 2'd2} wb_sel_e;

	// load width and extension
	typedef enum logic [2:0] {
		LS_LB  = 3'd0,
		LS_LH  = 3'd1,
		LS_LW  = 3'd2,
		LS_LBU = 3'd3,
		LS_LHU = 3'd4
	} ls_size_e;

endpackage

`default_nettype wire

//--- rtl/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// core sizing for the rv32i execution unit

// datapath width, fixed by rv32i
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// data memory depth in 32-bit words
// byte address bits above [1:0] pick the word
`define RV_DMEM_WORDS 64

`endif
